//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= remap_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+rtl
rtl/remap_flit_pkg.sv
rtl/remap_bus_pkg.sv
rtl/wb_if.sv
rtl/stream_xbar.sv
rtl/stream_remapper.sv
rtl/wb_lane_master.sv
rtl/wb_arbiter.sv
rtl/wb_sram.sv
rtl/remap_top.sv
tb/remap_assert.sv
tb/remap_tb.sv

//--- rtl/remap_bus_pkg.sv
//********************************************************************
// Wishbone bus types for the remap fabric.
//********************************************************************

`default_nettype none

`include "remap_settings.svh"

package remap_bus_pkg;

  typedef logic [`REMAP_ADDR_W-1:0] wb_addr_t;
  typedef logic [`REMAP_DATA_W-1:0] wb_data_t;

  // Index of the lane master that currently owns the shared bus.
  typedef logic [$clog2(`REMAP_NUM_PORTS)-1:0] mst_idx_t;

endpackage

`default_nettype wire

//--- rtl/remap_flit_pkg.sv
//********************************************************************
// Flit types for the remap fabric.
// Request and response flits exchanged with the requester ports.
//********************************************************************

`default_nettype none

`include "remap_settings.svh"

package remap_flit_pkg;

  // Index of the requester port that issued a flit.
  typedef logic [$clog2(`REMAP_NUM_PORTS)-1:0] src_id_t;

  typedef struct packed {
    logic                     we;
    logic [`REMAP_ADDR_W-1:0] addr;
    logic [`REMAP_DATA_W-1:0] wdata;
    src_id_t                  src;
  } req_flit_t;

  // Read data is only meaningful when we is low.
  typedef struct packed {
    logic                     we;
    logic [`REMAP_DATA_W-1:0] rdata;
    src_id_t                  src;
  } rsp_flit_t;

endpackage

`default_nettype wire

//--- rtl/remap_settings.svh
//********************************************************************
// Remap fabric settings.
// Port count, group size and bus widths shared by the whole design.
//********************************************************************

`ifndef REMAP_SETTINGS_SVH
`define REMAP_SETTINGS_SVH

// Requester ports, which is also the number of lanes behind the remapper.
`define REMAP_NUM_PORTS  4
// Lanes per remapping group. Must be a power of two.
`define REMAP_GROUP_SIZE 2
// Word address width of the shared memory.
`define REMAP_ADDR_W     6
`define REMAP_DATA_W     32

`endif

//--- rtl/remap_top.sv
//********************************************************************
// Remap fabric top level.
// Requester ports feed the rotating remapper, four Wishbone lanes and
// one shared SRAM behind a round-robin arbiter.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "remap_settings.svh"

module remap_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  remap_flit_pkg::req_flit_t [`REMAP_NUM_PORTS-1:0] req_i,
  input  logic                      [`REMAP_NUM_PORTS-1:0] req_valid_i,
  output logic                      [`REMAP_NUM_PORTS-1:0] req_ready_o,
  output remap_flit_pkg::rsp_flit_t [`REMAP_NUM_PORTS-1:0] rsp_o,
  output logic                      [`REMAP_NUM_PORTS-1:0] rsp_valid_o,
  input  logic                      [`REMAP_NUM_PORTS-1:0] rsp_ready_i
);
  import remap_flit_pkg::*;

  localparam int unsigned NumPorts = `REMAP_NUM_PORTS;

  req_flit_t [NumPorts-1:0] req_tagged;
  req_flit_t [NumPorts-1:0] lane_req;
  logic      [NumPorts-1:0] lane_valid;
  logic      [NumPorts-1:0] lane_ready;

  // Stamp each flit with its port so the response can be traced back.
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      req_tagged[p]     = req_i[p];
      req_tagged[p].src = src_id_t'(p);
    end
  end

  stream_remapper #(
    .NumPorts  (NumPorts),
    .GroupSize (`REMAP_GROUP_SIZE),
    .payload_t (req_flit_t)
  ) i_remapper (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (req_tagged),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_o  (lane_req),
    .valid_o (lane_valid),
    .ready_i (lane_ready)
  );

  wb_if lane_bus [NumPorts] ();
  wb_if mem_bus ();

  for (genvar l = 0; l < NumPorts; l++) begin : gen_lane
    wb_lane_master i_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (lane_req[l]),
      .req_valid_i (lane_valid[l]),
      .req_ready_o (lane_ready[l]),
      .rsp_o       (rsp_o[l]),
      .rsp_valid_o (rsp_valid_o[l]),
      .rsp_ready_i (rsp_ready_i[l]),
      .wb          (lane_bus[l])
    );
  end

  wb_arbiter i_arbiter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mst    (lane_bus),
    .slv    (mem_bus)
  );

  wb_sram i_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb     (mem_bus)
  );

endmodule

`default_nettype wire

//--- rtl/stream_remapper.sv
//********************************************************************
// Rotating stream remapper.
// Splits the ports into groups and spreads each group's traffic over
// its lanes with a selection pattern that rotates every cycle.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module stream_remapper #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned GroupSize = 2,
  parameter type         payload_t = logic
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  payload_t [NumPorts-1:0] data_i,
  input  logic     [NumPorts-1:0] valid_i,
  output logic     [NumPorts-1:0] ready_o,
  output payload_t [NumPorts-1:0] data_o,
  output logic     [NumPorts-1:0] valid_o,
  input  logic     [NumPorts-1:0] ready_i
);

  localparam int unsigned NumGroups = NumPorts / GroupSize;
  localparam int unsigned SelW      = (GroupSize > 1) ? $clog2(GroupSize) : 1;

  typedef logic [SelW-1:0] sel_t;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group
    localparam int unsigned Base = g * GroupSize;

    sel_t [GroupSize-1:0] sel_q;

    // Lower half of the inputs starts on the even lanes, upper half on the odd.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < GroupSize; i++) begin
          if (i < GroupSize / 2) begin
            sel_q[i] <= sel_t'(2 * i);
          end else begin
            sel_q[i] <= sel_t'(2 * i - GroupSize + 1);
          end
        end
      end else begin
        for (int i = 0; i < GroupSize; i++) begin
          sel_q[i] <= sel_q[(i + 1) % GroupSize];
        end
      end
    end

    stream_xbar #(
      .NumPorts  (GroupSize),
      .payload_t (payload_t)
    ) i_xbar (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .data_i  (data_i[Base +: GroupSize]),
      .sel_i   (sel_q),
      .valid_i (valid_i[Base +: GroupSize]),
      .ready_o (ready_o[Base +: GroupSize]),
      .data_o  (data_o[Base +: GroupSize]),
      .valid_o (valid_o[Base +: GroupSize]),
      .ready_i (ready_i[Base +: GroupSize])
    );
  end

endmodule

`default_nettype wire

//--- rtl/stream_xbar.sv
//********************************************************************
// Valid/ready stream crossbar.
// Every input names its output through sel_i; each output picks one
// of its requesters by round-robin.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module stream_xbar #(
  parameter int unsigned NumPorts = 2,
  parameter type         payload_t = logic,
  localparam int unsigned SelW = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  payload_t [NumPorts-1:0]        data_i,
  input  logic     [NumPorts-1:0][SelW-1:0] sel_i,
  input  logic     [NumPorts-1:0]        valid_i,
  output logic     [NumPorts-1:0]        ready_o,
  output payload_t [NumPorts-1:0]        data_o,
  output logic     [NumPorts-1:0]        valid_o,
  input  logic     [NumPorts-1:0]        ready_i
);

  typedef logic [SelW-1:0] idx_t;

  // Request matrix, indexed by output and then by input.
  logic [NumPorts-1:0][NumPorts-1:0] req;
  logic [NumPorts-1:0]               gnt_vld;
  idx_t [NumPorts-1:0]               gnt_idx;
  idx_t [NumPorts-1:0]               rr_q;

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req[o][i] = valid_i[i] && (sel_i[i] == idx_t'(o));
      end
    end
  end

  // Search each output's requesters starting at its round-robin pointer.
  always_comb begin
    int unsigned cand;
    cand = 0;
    for (int o = 0; o < NumPorts; o++) begin
      gnt_vld[o] = 1'b0;
      gnt_idx[o] = '0;
      for (int k = 0; k < NumPorts; k++) begin
        cand = (rr_q[o] + k) % NumPorts;
        if (!gnt_vld[o] && req[o][cand]) begin
          gnt_vld[o] = 1'b1;
          gnt_idx[o] = idx_t'(cand);
        end
      end
      valid_o[o] = gnt_vld[o];
      data_o[o]  = data_i[gnt_idx[o]];
    end
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_ready
    assign ready_o[i] = ready_i[sel_i[i]] && gnt_vld[sel_i[i]] &&
                        (gnt_idx[sel_i[i]] == idx_t'(i));
  end

  // The pointer moves past the winner only once its transfer completes,
  // so an input that keeps waiting is served next.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (valid_o[o] && ready_i[o]) begin
          rr_q[o] <= (gnt_idx[o] == idx_t'(NumPorts - 1)) ? '0 : gnt_idx[o] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/wb_arbiter.sv
//********************************************************************
// Round-robin Wishbone arbiter.
// Lets the lane masters share one slave, one cycle at a time.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "remap_settings.svh"

module wb_arbiter (
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  mst [`REMAP_NUM_PORTS],
  wb_if.master slv
);
  import remap_bus_pkg::*;

  localparam int unsigned NumMst = `REMAP_NUM_PORTS;

  logic     [NumMst-1:0] cyc_v;
  logic     [NumMst-1:0] stb_v;
  logic     [NumMst-1:0] we_v;
  wb_addr_t [NumMst-1:0] adr_v;
  wb_data_t [NumMst-1:0] dat_v;
  mst_idx_t              gnt_q;
  mst_idx_t              gnt_d;

  for (genvar m = 0; m < NumMst; m++) begin : gen_mst
    assign cyc_v[m] = mst[m].cyc;
    assign stb_v[m] = mst[m].stb;
    assign we_v[m]  = mst[m].we;
    assign adr_v[m] = mst[m].adr;
    assign dat_v[m] = mst[m].dat_w;
    // Only the owner of the bus ever sees an ack.
    assign mst[m].ack   = slv.ack && (gnt_q == mst_idx_t'(m));
    assign mst[m].dat_r = slv.dat_r;
  end

  // While the owner is idle, hand the bus to the next master with cyc high.
  always_comb begin
    int unsigned cand;
    logic        found;
    cand  = 0;
    found = 1'b0;
    gnt_d = gnt_q;
    if (!cyc_v[gnt_q]) begin
      for (int k = 1; k <= NumMst; k++) begin
        cand = (gnt_q + k) % NumMst;
        if (!found && cyc_v[cand]) begin
          found = 1'b1;
          gnt_d = mst_idx_t'(cand);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign slv.cyc   = cyc_v[gnt_q];
  assign slv.stb   = stb_v[gnt_q];
  assign slv.we    = we_v[gnt_q];
  assign slv.adr   = adr_v[gnt_q];
  assign slv.dat_w = dat_v[gnt_q];

endmodule

`default_nettype wire

//--- rtl/wb_if.sv
//********************************************************************
// Wishbone classic bus, single transfers only.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

interface wb_if;
  import remap_bus_pkg::*;

  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;

  modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
  modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

//--- rtl/wb_lane_master.sv
//********************************************************************
// Wishbone lane master.
// Runs one classic read or write cycle per request flit and returns
// one response flit.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module wb_lane_master (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  remap_flit_pkg::req_flit_t req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output remap_flit_pkg::rsp_flit_t rsp_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  wb_if.master                      wb
);
  import remap_flit_pkg::*;

  typedef enum logic [1:0] {StIdle, StBus, StRsp} state_e;

  state_e    state_q;
  req_flit_t req_q;
  rsp_flit_t rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:  if (req_valid_i) state_q <= StBus;
        StBus:   if (wb.ack) state_q <= StRsp;
        StRsp:   if (rsp_ready_i) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
    end
  end

  // The flit is held for the whole bus cycle; the response is built on ack.
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && req_valid_i) begin
      req_q <= req_i;
    end
    if (state_q == StBus && wb.ack) begin
      rsp_q <= '{we: req_q.we, rdata: wb.dat_r, src: req_q.src};
    end
  end

  assign req_ready_o = (state_q == StIdle);
  assign rsp_valid_o = (state_q == StRsp);
  assign rsp_o       = rsp_q;

  assign wb.cyc   = (state_q == StBus);
  assign wb.stb   = (state_q == StBus);
  assign wb.we    = req_q.we;
  assign wb.adr   = req_q.addr;
  assign wb.dat_w = req_q.wdata;

endmodule

`default_nettype wire

//--- rtl/wb_sram.sv
//********************************************************************
// Wishbone SRAM slave.
// Word-addressed memory that acks every access after one cycle.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "remap_settings.svh"

module wb_sram (
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  wb
);
  import remap_bus_pkg::*;

  localparam int unsigned Depth = 2 ** `REMAP_ADDR_W;

  wb_data_t mem [Depth];
  wb_data_t rdata_q;
  logic     ack_q;
  logic     access;

  // The ack cycle itself must not start a second access.
  assign access = wb.cyc && wb.stb && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (wb.we) begin
        mem[wb.adr] <= wb.dat_w;
      end
      rdata_q <= mem[wb.adr];
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = rdata_q;

endmodule

`default_nettype wire

//--- tb/remap_assert.sv
//********************************************************************
// Bound checks on the remapper streams and the shared Wishbone bus.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "remap_settings.svh"

module remap_assert #(
  parameter bit BusSide = 1'b0
) (
  input logic                                                        clk_i,
  input logic                                                        rst_ni,
  input logic [`REMAP_NUM_PORTS-1:0]                                 valid_i,
  input logic [`REMAP_NUM_PORTS-1:0]                                 in_ready_i,
  input logic [`REMAP_NUM_PORTS*$bits(remap_flit_pkg::req_flit_t)-1:0] data_i,
  input logic [`REMAP_NUM_PORTS-1:0]                                 lane_valid_i,
  input logic [`REMAP_NUM_PORTS-1:0]                                 cyc_i,
  input remap_bus_pkg::mst_idx_t                                     gnt_i,
  input logic                                                        ack_i
);
  import remap_flit_pkg::*;

  localparam int unsigned NumPorts  = `REMAP_NUM_PORTS;
  localparam int unsigned GroupSize = `REMAP_GROUP_SIZE;
  localparam int unsigned FlitW     = $bits(req_flit_t);

  if (!BusSide) begin : gen_stream
    initial begin
      assert ((GroupSize & (GroupSize - 1)) == 0)
        else $error("Group size %0d is not a power of two", GroupSize);
      assert (NumPorts % GroupSize == 0)
        else $error("Port count %0d is not a multiple of the group size", NumPorts);
    end

    // With a permutation every valid input owns a lane of its own.
    for (genvar g = 0; g < NumPorts / GroupSize; g++) begin : gen_group
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        $countones(lane_valid_i[g*GroupSize +: GroupSize]) ==
        $countones(valid_i[g*GroupSize +: GroupSize]))
        else $error("Group %0d sent two inputs to one lane", g);
    end

    for (genvar p = 0; p < NumPorts; p++) begin : gen_port
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i[p] && !in_ready_i[p] |=> valid_i[p] && $stable(data_i[p*FlitW +: FlitW]))
        else $error("Port %0d changed its request under back-pressure", p);
    end
  end else begin : gen_bus
    assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |=> !ack_i)
      else $error("Shared bus ack lasted more than one cycle");

    assert property (@(posedge clk_i) disable iff (!rst_ni) cyc_i[gnt_i] |=> $stable(gnt_i))
      else $error("Bus grant moved while its owner held cyc");
  end

endmodule

bind stream_remapper remap_assert #(.BusSide(1'b0)) i_stream_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      (valid_i),
  .in_ready_i   (ready_o),
  .data_i       (data_i),
  .lane_valid_i (valid_o),
  .cyc_i        ('0),
  .gnt_i        ('0),
  .ack_i        (1'b0)
);

bind wb_arbiter remap_assert #(.BusSide(1'b1)) i_bus_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .valid_i      ('0),
  .in_ready_i   ('0),
  .data_i       ('0),
  .lane_valid_i ('0),
  .cyc_i        (cyc_v),
  .gnt_i        (gnt_q),
  .ack_i        (slv.ack)
);

`default_nettype wire

//--- tb/remap_tb.sv
//********************************************************************
// Remap fabric testbench.
// Random reads and writes on every port are checked against a memory
// model and per-port counts of requests in flight.
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "remap_settings.svh"

module remap_tb;
  import remap_flit_pkg::*;

  localparam int unsigned NumPorts   = `REMAP_NUM_PORTS;
  localparam int unsigned GroupSize  = `REMAP_GROUP_SIZE;
  localparam int unsigned Depth      = 2 ** `REMAP_ADDR_W;
  localparam int unsigned LowW       = `REMAP_ADDR_W - $clog2(NumPorts);
  localparam int unsigned OpsPerPort = 16;
  // The limit covers 64 operations at a worst case of 40 cycles each.
  localparam int unsigned MaxCycles  = 4000;

  logic                     clk;
  logic                     rst_n;
  req_flit_t [NumPorts-1:0] req;
  logic      [NumPorts-1:0] req_valid;
  logic      [NumPorts-1:0] req_ready;
  rsp_flit_t [NumPorts-1:0] rsp;
  logic      [NumPorts-1:0] rsp_valid;
  logic      [NumPorts-1:0] rsp_ready;

  logic [15:0] lfsr_q;
  int unsigned cycle_cnt = 0;

  // Scoreboard state is updated on the rising edge.
  logic [`REMAP_DATA_W-1:0] model    [Depth];
  logic [`REMAP_DATA_W-1:0] exp_data [NumPorts];
  logic                     exp_we   [NumPorts];
  int                       outstanding [NumPorts];
  int unsigned              acc_cnt  [NumPorts];
  int unsigned              rsp_cnt  [NumPorts];
  logic      [NumPorts-1:0] hold_q;
  rsp_flit_t [NumPorts-1:0] rsp_prev;

  // Stimulus state is updated on the falling edge.
  int unsigned issued  [NumPorts];
  logic        written [Depth];

  remap_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic print_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic explain_error(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  // Fibonacci LFSR with the taps of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      if (rsp_cnt[p] != OpsPerPort) done = 1'b0;
    end
    return done;
  endfunction

  // Each port only touches the addresses whose top bits equal its index.
  // An address that was never written is written first.
  task automatic issue_request(input int unsigned p);
    logic [LowW-1:0]          low;
    logic [`REMAP_ADDR_W-1:0] addr;
    logic                     we;
    low  = LowW'(take_bits(LowW));
    addr = {src_id_t'(p), low};
    we   = (take_bits(1) != 32'd0);
    if (!written[addr]) we = 1'b1;
    if (we) written[addr] = 1'b1;
    req[p].we    = we;
    req[p].addr  = addr;
    req[p].wdata = take_bits(32);
    req[p].src   = src_id_t'(p);
    req_valid[p] = 1'b1;
    issued[p]    = issued[p] + 1;
  endtask

  task automatic accept_request(input int unsigned p);
    exp_we[p] = req[p].we;
    if (req[p].we) begin
      model[req[p].addr] = req[p].wdata;
    end else begin
      exp_data[p] = model[req[p].addr];
    end
    outstanding[p] = outstanding[p] + 1;
    acc_cnt[p]     = acc_cnt[p] + 1;
  endtask

  task automatic check_response(input int unsigned l);
    src_id_t s;
    s = rsp[l].src;
    assert (l / GroupSize == int'(s) / GroupSize)
      else explain_error($sformatf("Lane %0d answered port %0d of another group", l, s));
    assert (outstanding[s] > 0)
      else explain_error($sformatf("Lane %0d answered port %0d with nothing in flight", l, s));
    outstanding[s] = outstanding[s] - 1;
    rsp_cnt[s]     = rsp_cnt[s] + 1;
    assert (rsp[l].we == exp_we[s])
      else print_mismatch("rsp_o.we", 64'(rsp[l].we), 64'(exp_we[s]));
    if (!exp_we[s]) begin
      assert (rsp[l].rdata == exp_data[s])
        else print_mismatch("rsp_o.rdata", 64'(rsp[l].rdata), 64'(exp_data[s]));
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < NumPorts; p++) begin
        outstanding[p] = 0;
        acc_cnt[p]     = 0;
        rsp_cnt[p]     = 0;
        exp_we[p]      = 1'b0;
        exp_data[p]    = '0;
      end
      hold_q = '0;
    end else begin
      for (int l = 0; l < NumPorts; l++) begin
        // A response left waiting on the last edge must still be there unchanged.
        if (hold_q[l]) begin
          assert (rsp_valid[l])
            else explain_error($sformatf("Lane %0d dropped a response before it was taken", l));
          assert (rsp[l] == rsp_prev[l])
            else print_mismatch($sformatf("rsp_o[%0d]", l), 64'(rsp[l]), 64'(rsp_prev[l]));
        end
        hold_q[l]   = rsp_valid[l] && !rsp_ready[l];
        rsp_prev[l] = rsp[l];
        if (rsp_valid[l] && rsp_ready[l]) check_response(l);
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (req_valid[p] && req_ready[p]) accept_request(p);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      explain_error($sformatf("Timeout after %0d cycles with responses still missing",
                              cycle_cnt));
    end
  end

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    req_valid = '0;
    rsp_ready = '0;
    lfsr_q    = 16'd75;
    for (int a = 0; a < Depth; a++) written[a] = 1'b0;
    for (int p = 0; p < NumPorts; p++) issued[p] = 0;
    repeat (10) @(negedge clk);
    assert (rsp_valid == '0) else print_mismatch("rsp_valid_o", 64'(rsp_valid), 64'd0);
    rst_n = 1'b1;
    @(negedge clk);
    assert (rsp_valid == '0) else print_mismatch("rsp_valid_o", 64'(rsp_valid), 64'd0);

    // All ports start together on the first cycle with one request in flight each.
    while (!all_done()) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (req_valid[p] && acc_cnt[p] == issued[p]) req_valid[p] = 1'b0;
        if (!req_valid[p] && rsp_cnt[p] == issued[p] && issued[p] < OpsPerPort) begin
          issue_request(p);
        end
      end
      for (int l = 0; l < NumPorts; l++) begin
        rsp_ready[l] = (take_bits(2) != 32'd0);
      end
      @(negedge clk);
    end

    for (int p = 0; p < NumPorts; p++) begin
      assert (outstanding[p] == 0)
        else explain_error($sformatf("Port %0d ended with %0d requests in flight",
                                     p, outstanding[p]));
    end
    // Once the last response is taken no lane may offer another one.
    assert (rsp_valid == '0)
      else print_mismatch("rsp_valid_o", 64'(rsp_valid), 64'd0);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
